// ==== design/lsu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  lsu_pkg::lsu_bus_req_t i_req,
   output logic [31:0]           o_rdt,
   output logic                  o_ack
);

   logic [31:0] mem [lsu_pkg::LSU_RAM_WORDS];

   logic [$clog2(lsu_pkg::LSU_RAM_LATENCY + 1)-1:0] cnt;
   logic [lsu_pkg::LSU_RAM_AW-1:0]                 waddr;
   logic                                           last;

   assign waddr = i_req.adr[lsu_pkg::LSU_RAM_AW+1:2];  // Higher bits alias.
   assign last  = (cnt == lsu_pkg::LSU_RAM_LATENCY - 1);

   // Latency counter, ack is a single pulse.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cnt   <= '0;
         o_ack <= 1'b0;
      end else if (o_ack) begin
         cnt   <= '0;
         o_ack <= 1'b0;
      end else if (i_req.cyc) begin
         if (last) begin
            cnt   <= '0;
            o_ack <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end else begin
         cnt <= '0;
      end
   end

   // Read word is ready in the ack cycle.
   always_ff @(posedge i_clk) begin
      if (i_req.cyc & ~o_ack & last)
         o_rdt <= mem[waddr];
   end

   always_ff @(posedge i_clk) begin
      if (i_req.cyc & o_ack & i_req.we) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (i_req.sel[lane])
               mem[waddr][8*lane +: 8] <= i_req.dat[8*lane +: 8];
         end
      end
   end

   a_cyc_held: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (i_req.cyc & ~o_ack) |=> i_req.cyc
   );

endmodule

`default_nettype wire

// ==== design/lsu_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_if (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_en,
   input  logic                  i_init,
   input  logic                  i_dat_valid,
   input  logic                  i_cmd,
   input  logic [2:0]            i_funct3,
   input  logic                  i_rs1,
   input  logic                  i_rs2,
   input  logic                  i_imm,
   input  logic                  i_trap,
   input  logic [31:0]           i_rdt,
   input  logic                  i_ack,
   output logic                  o_rd,
   output logic                  o_misalign,
   output lsu_pkg::lsu_bus_req_t o_req
);

   lsu_pkg::lsu_width_e width;

   logic                        adr_bit;
   logic [lsu_pkg::LSU_XLEN-1:0] adr_q;
   logic [lsu_pkg::LSU_XLEN-1:0] dat;
   logic [31:0]                 st_dat;
   logic [31:0]                 ld_dat;
   logic [3:0]                  sel;
   logic [1:0]                  bytepos;
   logic [1:0]                  misalign;
   logic                        init_r;
   logic                        init_2r;
   logic                        en_r;
   logic                        en_2r;
   logic                        cyc;
   logic                        signbit;
   logic                        is_signed;
   logic                        is_word;
   logic                        is_byte;
   logic                        load_ack;

   assign width     = lsu_pkg::lsu_width_e'(i_funct3[1:0]);
   assign is_word   = (width == lsu_pkg::LSU_WORD);
   assign is_byte   = (width == lsu_pkg::LSU_BYTE);
   assign is_signed = ~i_funct3[2];
   assign load_ack  = cyc & i_ack & ~i_cmd;

   // Address is rs1 + imm, one bit per cycle.
   ser_add u_ser_add (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_a      (i_rs1),
      .i_b      (i_imm),
      .i_clr    (~i_en),
      .o_q      (adr_bit)
   );

   // Keeps shifting under a trap so the faulting address is preserved.
   shift_reg u_shift_reg_adr (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (i_init | (i_en & i_trap)),
      .i_d      (adr_bit),
      .o_q      (adr_q)
   );

   always_comb begin
      case (width)
         lsu_pkg::LSU_WORD: sel = 4'b1111;
         lsu_pkg::LSU_HALF: sel = bytepos[1] ? 4'b1100 : 4'b0011;
         default:           sel = 4'b0001 << bytepos;
      endcase
   end

   // Narrow stores go out on every lane.
   always_comb begin
      case (width)
         lsu_pkg::LSU_WORD: st_dat = dat;
         lsu_pkg::LSU_HALF: st_dat = {2{dat[15:0]}};
         default:           st_dat = {4{dat[7:0]}};
      endcase
   end

   // Addressed field lands in the low bits, upper bits stay as read.
   always_comb begin
      ld_dat = i_rdt;
      case (width)
         lsu_pkg::LSU_HALF: begin
            if (bytepos[1])
               ld_dat[15:0] = i_rdt[31:16];
         end
         lsu_pkg::LSU_BYTE: ld_dat[7:0] = i_rdt[{bytepos, 3'b000} +: 8];
         default: ;
      endcase
   end

   always_comb begin
      o_req.adr = adr_q;
      o_req.dat = st_dat;
      o_req.sel = sel;
      o_req.we  = i_cmd;
      o_req.cyc = cyc;
   end

   assign o_misalign = |misalign;
   assign o_rd = i_dat_valid ? dat[0] : (signbit & is_signed);  // Extend past valid bits.

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         init_r  <= 1'b0;
         init_2r <= 1'b0;
         en_r    <= 1'b0;
         en_2r   <= 1'b0;
      end else begin
         init_r  <= i_init;
         init_2r <= init_r;
         en_r    <= i_en;
         en_2r   <= en_r;
      end
   end

   // First two address bits come out in the first two cycles.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         bytepos  <= 2'b00;
         misalign <= 2'b00;
      end else begin
         if (i_en & ~en_r)
            bytepos[0] <= adr_bit;
         if (en_r & ~en_2r)
            bytepos[1] <= adr_bit;
         if (!i_en) begin
            misalign <= 2'b00;
         end else begin
            if (i_init & ~init_r)
               misalign[0] <= ~is_byte & adr_bit;
            if (init_r & ~init_2r)
               misalign[1] <= is_word & adr_bit;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cyc <= 1'b0;
      end else if (cyc & i_ack) begin
         cyc <= 1'b0;
      end else if (init_r & ~i_init & ~i_trap) begin
         cyc <= 1'b1;  // One cycle after init ends.
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         dat     <= '0;
         signbit <= 1'b0;
      end else begin
         if (load_ack)
            dat <= ld_dat;
         else if (i_en)
            dat <= {i_rs2, dat[lsu_pkg::LSU_XLEN-1:1]};
         if (i_dat_valid)
            signbit <= dat[0];
      end
   end

   a_no_cyc_on_trap: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      $rose(cyc) |-> $past(~i_trap)
   );

   a_sel_nonzero: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      cyc |-> (sel != 4'b0000)
   );

   a_ack_needs_cyc: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      i_ack |-> cyc
   );

endmodule

`default_nettype wire

// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   localparam int LSU_XLEN = 32;        // Also the length of one serial phase.
   localparam int LSU_RAM_WORDS = 64;
   localparam int LSU_RAM_AW = 6;
   localparam int LSU_RAM_LATENCY = 2;  // Cycles from cyc rise to ack.

   // Low two bits of funct3.
   typedef enum logic [1:0] {
      LSU_BYTE = 2'b00,
      LSU_HALF = 2'b01,
      LSU_WORD = 2'b10
   } lsu_width_e;

   // Single-beat request, held stable until ack.
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } lsu_bus_req_t;

endpackage

`default_nettype wire

// ==== design/ser_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module ser_add (
   input  logic i_clk,
   input  logic i_arst_n,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry;
   logic carry_nxt;

   assign o_q = i_a ^ i_b ^ carry;
   assign carry_nxt = (i_a & i_b) | (i_a & carry) | (i_b & carry);

   // Carry ripples one bit per clock.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry <= 1'b0;
      end else if (i_clr) begin
         carry <= 1'b0;  // Fresh start for the next operand.
      end else begin
         carry <= carry_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== design/serial_lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_lsu_top (
   input  logic       i_clk,
   input  logic       i_arst_n,
   input  logic       i_en,
   input  logic       i_init,
   input  logic       i_dat_valid,
   input  logic       i_cmd,
   input  logic [2:0] i_funct3,
   input  logic       i_rs1,
   input  logic       i_rs2,
   input  logic       i_imm,
   input  logic       i_trap,
   output logic       o_rd,
   output logic       o_misalign,
   output logic       o_done
);

   lsu_pkg::lsu_bus_req_t req;
   logic [31:0]           rdt;

   lsu_mem_if u_lsu_mem_if (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_en        (i_en),
      .i_init      (i_init),
      .i_dat_valid (i_dat_valid),
      .i_cmd       (i_cmd),
      .i_funct3    (i_funct3),
      .i_rs1       (i_rs1),
      .i_rs2       (i_rs2),
      .i_imm       (i_imm),
      .i_trap      (i_trap),
      .i_rdt       (rdt),
      .i_ack       (o_done),
      .o_rd        (o_rd),
      .o_misalign  (o_misalign),
      .o_req       (req)
   );

   // Ack doubles as the done pulse to the core.
   lsu_data_ram u_lsu_data_ram (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_req    (req),
      .o_rdt    (rdt),
      .o_ack    (o_done)
   );

endmodule

`default_nettype wire

// ==== design/shift_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_reg (
   input  logic                        i_clk,
   input  logic                        i_arst_n,
   input  logic                        i_en,
   input  logic                        i_d,
   output logic [lsu_pkg::LSU_XLEN-1:0] o_q
);

   // LSB arrives first, so new bits enter at the top.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_q <= '0;
      end else if (i_en) begin
         o_q <= {i_d, o_q[lsu_pkg::LSU_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

// ==== project.f ====
design/lsu_pkg.sv
design/ser_add.sv
design/shift_reg.sv
design/lsu_mem_if.sv
design/lsu_data_ram.sv
design/serial_lsu_top.sv
sim/tb_serial_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Runs from the project root so the testbench finds its data file.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_lsu \
   -f project.f -o sim_serial_lsu > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_serial_lsu > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/lsu_testdata.txt ====
# kind funct3 rs1 imm rs2 expected, numbers in hex
# expected is the loaded word, store and trap lines leave it at zero
store 2 00000010 00000004 deadbeef 00000000
load  2 00000014 00000000 00000000 deadbeef
store 2 00000020 00000000 11223344 00000000
store 0 00000020 00000000 0000005a 00000000
load  2 00000020 00000000 00000000 1122335a
store 0 0000001f 00000002 abcdef6b 00000000
store 0 00000030 fffffff2 0000007c 00000000
store 0 00000023 00000000 0000008d 00000000
load  2 00000020 00000000 00000000 8d7c6b5a
load  0 00000020 00000000 00000000 0000005a
load  0 00000023 00000000 00000000 ffffff8d
load  4 00000023 00000000 00000000 0000008d
load  1 00000020 00000000 00000000 00006b5a
load  1 00000022 00000000 00000000 ffff8d7c
load  5 00000022 00000000 00000000 00008d7c
load  4 00000015 00000000 00000000 000000be
trap  1 00000021 00000000 00001234 00000000
trap  2 00000020 00000002 ffffffff 00000000
trap  2 00000014 00000000 12345678 00000000
load  2 00000020 00000000 00000000 8d7c6b5a
load  1 00000016 00000000 00000000 ffffdead
store 2 0000002f 00000011 cafef00d 00000000
load  2 00000040 00000000 00000000 cafef00d
load  2 00000048 fffffff8 00000000 cafef00d
load  2 ffffffff 00000041 00000000 cafef00d
load  2 00000100 00000040 00000000 cafef00d
store 1 00000040 00000002 1234beef 00000000
load  2 00000040 00000000 00000000 beeff00d
load  5 00000042 00000000 00000000 0000beef

// ==== sim/tb_serial_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_serial_lsu;

   localparam int DONE_TIMEOUT = 20;

   logic       clk;
   logic       arst_n;
   logic       en;
   logic       init;
   logic       dat_valid;
   logic       cmd;
   logic [2:0] funct3;
   logic       rs1;
   logic       rs2;
   logic       imm;
   logic       trap;
   logic       rd;
   logic       misalign;
   logic       done;

   logic [31:0] model_mem [lsu_pkg::LSU_RAM_WORDS];  // What the RAM should hold.

   serial_lsu_top u_serial_lsu_top (
      .i_clk       (clk),
      .i_arst_n    (arst_n),
      .i_en        (en),
      .i_init      (init),
      .i_dat_valid (dat_valid),
      .i_cmd       (cmd),
      .i_funct3    (funct3),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .i_trap      (trap),
      .o_rd        (rd),
      .o_misalign  (misalign),
      .o_done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected)
         abort_run($sformatf("MISMATCH %s expected %08h actual %08h", name, expected, actual));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
   endtask

   // Halfword needs bit 0 clear, word needs both low bits clear.
   function automatic logic expected_misalign(input logic [2:0] f3, input logic [31:0] adr);
      case (f3[1:0])
         lsu_pkg::LSU_WORD: return adr[1] | adr[0];
         lsu_pkg::LSU_HALF: return adr[0];
         default:           return 1'b0;
      endcase
   endfunction

   task automatic store_to_model(input logic [2:0] f3, input logic [31:0] adr,
                                 input logic [31:0] data);
      logic [lsu_pkg::LSU_RAM_AW-1:0] idx;
      idx = adr[lsu_pkg::LSU_RAM_AW+1:2];
      case (f3[1:0])
         lsu_pkg::LSU_WORD: model_mem[idx] = data;
         lsu_pkg::LSU_HALF: model_mem[idx][{adr[1], 4'b0000} +: 16] = data[15:0];
         default:           model_mem[idx][{adr[1:0], 3'b000} +: 8] = data[7:0];
      endcase
   endtask

   function automatic logic [31:0] load_from_model(input logic [2:0] f3,
                                                   input logic [31:0] adr);
      logic [31:0] word;
      logic [15:0] half;
      logic [7:0]  byte_v;
      logic        fill;
      word   = model_mem[adr[lsu_pkg::LSU_RAM_AW+1:2]];
      half   = word[{adr[1], 4'b0000} +: 16];
      byte_v = word[{adr[1:0], 3'b000} +: 8];
      fill   = ~f3[2];  // Bit 2 set means zero extension.
      case (f3[1:0])
         lsu_pkg::LSU_WORD: return word;
         lsu_pkg::LSU_HALF: return {{16{half[15] & fill}}, half};
         default:           return {{24{byte_v[7] & fill}}, byte_v};
      endcase
   endfunction

   task automatic drive_idle();
      @(posedge clk);
      #1;
      en        = 1'b0;
      init      = 1'b0;
      dat_valid = 1'b0;
      rs1       = 1'b0;
      rs2       = 1'b0;
      imm       = 1'b0;
   endtask

   task automatic run_init_phase(input string name, input logic [2:0] f3, input logic cmd_v,
                                 input logic trap_v, input logic [31:0] rs1_v,
                                 input logic [31:0] imm_v, input logic [31:0] rs2_v);
      for (int i = 0; i < lsu_pkg::LSU_XLEN; i++) begin
         @(posedge clk);
         #1;
         en     = 1'b1;
         init   = 1'b1;
         cmd    = cmd_v;
         funct3 = f3;
         trap   = trap_v;
         rs1    = rs1_v[i];  // LSB first.
         imm    = imm_v[i];
         rs2    = rs2_v[i];
      end
      @(negedge clk);
      check_flag({name, " misalign"}, expected_misalign(f3, rs1_v + imm_v), misalign);
   endtask

   task automatic wait_for_done(input string name, input logic trapped);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < DONE_TIMEOUT) begin
         @(negedge clk);
         seen = done;
         waited++;
      end
      if (trapped) begin
         if (seen)
            abort_run($sformatf("%s: o_done pulsed although the access was trapped", name));
      end else begin
         if (!seen)
            abort_run($sformatf("%s: no o_done within %0d cycles", name, DONE_TIMEOUT));
         check_word({name, " latency"}, 1 + lsu_pkg::LSU_RAM_LATENCY, waited - 1);
         drive_idle();
         @(negedge clk);
         check_flag({name, " done pulse width"}, 1'b0, done);
      end
   endtask

   task automatic run_readout(input logic [2:0] f3, output logic [31:0] result);
      int valid_bits;
      case (f3[1:0])
         lsu_pkg::LSU_WORD: valid_bits = 32;
         lsu_pkg::LSU_HALF: valid_bits = 16;
         default:           valid_bits = 8;
      endcase
      result = '0;
      for (int i = 0; i < lsu_pkg::LSU_XLEN; i++) begin
         @(posedge clk);
         #1;
         en        = 1'b1;
         init      = 1'b0;
         dat_valid = (i < valid_bits);
         @(negedge clk);
         result[i] = rd;
      end
      drive_idle();
   endtask

   initial begin
      int          fd;
      int          count;
      int          n_ops;
      string       line;
      string       name;
      string       kind_name;
      logic [63:0] kind;
      logic [2:0]  f3;
      logic [31:0] rs1_v;
      logic [31:0] imm_v;
      logic [31:0] rs2_v;
      logic [31:0] file_exp;
      logic [31:0] result;
      logic [31:0] adr;
      logic        cmd_v;
      logic        trap_v;

      void'($urandom(764));
      arst_n    = 1'b0;
      en        = 1'b0;
      init      = 1'b0;
      dat_valid = 1'b0;
      cmd       = 1'b0;
      funct3    = 3'b000;
      rs1       = 1'b0;
      rs2       = 1'b0;
      imm       = 1'b0;
      trap      = 1'b0;
      for (int w = 0; w < lsu_pkg::LSU_RAM_WORDS; w++)
         model_mem[w] = 'x;
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;

      fd = $fopen("sim/lsu_testdata.txt", "r");
      if (fd == 0)
         abort_run("could not open sim/lsu_testdata.txt for reading");
      n_ops = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         count = $sscanf(line, "%s %h %h %h %h %h", kind, f3, rs1_v, imm_v, rs2_v, file_exp);
         if (count != 6)
            abort_run($sformatf("malformed line in the data file: %s", line));
         if (kind == "store") begin
            kind_name = "store";
            cmd_v     = 1'b1;
            trap_v    = 1'b0;
         end else if (kind == "load") begin
            kind_name = "load";
            cmd_v     = 1'b0;
            trap_v    = 1'b0;
         end else if (kind == "trap") begin
            kind_name = "trap";
            cmd_v     = 1'b1;  // Trapped stores must leave memory alone.
            trap_v    = 1'b1;
         end else begin
            abort_run($sformatf("unknown operation kind in the data file: %s", line));
         end
         n_ops++;
         name = $sformatf("op%0d_%s", n_ops, kind_name);
         adr  = rs1_v + imm_v;

         run_init_phase(name, f3, cmd_v, trap_v, rs1_v, imm_v, rs2_v);
         drive_idle();
         wait_for_done(name, trap_v);
         if (trap_v) begin
            @(posedge clk);
            #1;
            trap = 1'b0;
         end else if (cmd_v) begin
            store_to_model(f3, adr, rs2_v);
         end else begin
            run_readout(f3, result);
            check_word(name, file_exp, result);
            check_word({name, " model"}, load_from_model(f3, adr), result);
         end
         repeat ($urandom % 4) drive_idle();
      end
      $fclose(fd);

      if (n_ops == 0) begin
         abort_run("the data file held no operations");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
